/* common/ooo_pkg.sv */
package ooo_pkg;

  localparam int DATA_W     = 16;  // Operand and result width
  localparam int TAG_W      = 4;   // Physical tag width
  localparam int AREG_W     = 3;   // Architectural register number width
  localparam int NUM_TAGS   = 16;  // Tag 0 is the zero register
  localparam int NUM_AREGS  = 8;
  localparam int NUM_RS     = 3;   // One station entry per unit
  localparam int MUL_STAGES = 3;   // Multiplier latency in cycles

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [AREG_W-1:0] areg_t;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    XOR = 3'd3,
    LI  = 3'd4,  // Writes the immediate
    MUL = 3'd5
  } op_t;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_t;

  // Unit bound to each entry, ALU0 ALU1 MUL
  localparam fu_t RS_FU_LIST [NUM_RS] = '{FU_ALU, FU_ALU, FU_MUL};

  function automatic fu_t op_fu(op_t op);
    return (op == MUL) ? FU_MUL : FU_ALU;  // Everything else runs on an ALU
  endfunction

endpackage

/* common/ooo_ifs.sv */
`timescale 1ns/1ps

interface dispatch_if import ooo_pkg::*; ();
  logic  dispatch_en;  // Accept strobe from decode
  fu_t   fu;           // Unit type the instruction needs
  op_t   op;
  tag_t  dest_tag;     // Freshly allocated tag
  tag_t  src1_tag;
  logic  src1_ready;
  tag_t  src2_tag;
  logic  src2_ready;
  data_t imm;
  logic  slot_free;    // Matching entry empty or issuing

  modport source (output dispatch_en, fu, op, dest_tag, src1_tag, src1_ready,
                  src2_tag, src2_ready, imm, input slot_free);
  modport sink   (input dispatch_en, fu, op, dest_tag, src1_tag, src1_ready,
                  src2_tag, src2_ready, imm, output slot_free);
endinterface

interface issue_if import ooo_pkg::*; #(parameter int NUM_RS = ooo_pkg::NUM_RS) ();
  logic [NUM_RS-1:0] issue;               // Per entry issue strobe
  op_t               op       [NUM_RS];
  tag_t              dest_tag [NUM_RS];
  tag_t              src1_tag [NUM_RS];
  tag_t              src2_tag [NUM_RS];
  data_t             imm      [NUM_RS];
  logic [NUM_RS-1:0] fu_free;             // Unit can take work this cycle

  modport source (output issue, op, dest_tag, src1_tag, src2_tag, imm, input fu_free);
  modport sink   (input issue, op, dest_tag, src1_tag, src2_tag, imm, output fu_free);
endinterface

interface cdb_if import ooo_pkg::*; #(parameter int NUM_RS = ooo_pkg::NUM_RS) ();
  logic              cdb_valid;  // One cycle per completion
  tag_t              cdb_tag;
  data_t             cdb_value;
  logic [NUM_RS-1:0] grant;      // Unit whose buffer drains now

  modport source  (output cdb_valid, cdb_tag, cdb_value, grant);
  modport monitor (input cdb_valid, cdb_tag, cdb_value, grant);
endinterface

/* execute/mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe import ooo_pkg::*; #(
  parameter int MUL_STAGES = ooo_pkg::MUL_STAGES  // At least 2
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  in_valid,
  input  tag_t  in_tag,
  input  data_t a,
  input  data_t b,
  input  logic  hold,
  output logic  out_valid,
  output tag_t  out_tag,
  output data_t out_value
);

  logic [MUL_STAGES-1:0] vld;
  tag_t                  tag_q [MUL_STAGES];
  data_t                 val_q [MUL_STAGES];  // Stage 0 holds the low partial product
  logic [7:0]            part_hi;             // a times b upper byte, low byte only

  always_ff @(posedge clock) begin
    if (reset) begin
      vld <= '0;
    end else if (!hold) begin
      vld <= {vld[MUL_STAGES-2:0], in_valid};
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin  // Whole pipe freezes together
      tag_q[0] <= in_tag;
      val_q[0] <= a * {8'd0, b[7:0]};
      part_hi  <= a[7:0] * b[15:8];
      tag_q[1] <= tag_q[0];
      val_q[1] <= val_q[0] + {part_hi, 8'd0};  // Low 16 bits of the product
      for (int s = 2; s < MUL_STAGES; s++) begin
        tag_q[s] <= tag_q[s-1];
        val_q[s] <= val_q[s-1];
      end
    end
  end

  assign out_valid = vld[MUL_STAGES-1];
  assign out_tag   = tag_q[MUL_STAGES-1];
  assign out_value = val_q[MUL_STAGES-1];

endmodule

/* execute/execute_units.sv */
`timescale 1ns/1ps

module execute_units import ooo_pkg::*; #(
  parameter int NUM_RS     = ooo_pkg::NUM_RS,
  parameter int MUL_STAGES = ooo_pkg::MUL_STAGES
) (
  input  logic              clock,
  input  logic              reset,
  issue_if.sink             iss,
  cdb_if.monitor            cdb,
  output logic [NUM_RS-1:0] res_valid,
  output tag_t              res_tag   [NUM_RS],
  output data_t             res_value [NUM_RS],
  input  logic [NUM_RS-1:0] buf_full,
  output tag_t              rf_tag1   [NUM_RS],
  output tag_t              rf_tag2   [NUM_RS],
  input  data_t             rf_val1   [NUM_RS],
  input  data_t             rf_val2   [NUM_RS],
  output logic              busy
);

  logic [NUM_RS-1:0] hold;       // Result buffer blocked
  logic [NUM_RS-1:0] unit_busy;
  data_t             opa [NUM_RS];
  data_t             opb [NUM_RS];

  assign rf_tag1 = iss.src1_tag;
  assign rf_tag2 = iss.src2_tag;
  assign busy    = |unit_busy;

  for (genvar i = 0; i < NUM_RS; i++) begin : g_unit
    // Bypass the value being broadcast this cycle
    assign opa[i] = (cdb.cdb_valid && cdb.cdb_tag == iss.src1_tag[i]) ? cdb.cdb_value
                                                                       : rf_val1[i];
    assign opb[i] = (cdb.cdb_valid && cdb.cdb_tag == iss.src2_tag[i]) ? cdb.cdb_value
                                                                       : rf_val2[i];
    assign hold[i]        = buf_full[i] && !cdb.grant[i];
    assign iss.fu_free[i] = !hold[i];

    if (RS_FU_LIST[i] == FU_ALU) begin : g_alu
      data_t alu_out;
      always_comb begin
        case (iss.op[i])
          ADD:     alu_out = opa[i] + opb[i];
          SUB:     alu_out = opa[i] - opb[i];
          AND:     alu_out = opa[i] & opb[i];
          XOR:     alu_out = opa[i] ^ opb[i];
          LI:      alu_out = iss.imm[i];
          default: alu_out = '0;  // MUL never reaches an ALU entry
        endcase
      end
      assign res_valid[i] = iss.issue[i];  // Buffered at the end of the issue cycle
      assign res_tag[i]   = iss.dest_tag[i];
      assign res_value[i] = alu_out;
      assign unit_busy[i] = 1'b0;
    end else begin : g_mul
      localparam int CNT_W = $clog2(MUL_STAGES + 2);
      logic             pipe_valid;
      logic [CNT_W-1:0] in_flight;  // Products still inside the pipe

      mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (iss.issue[i]),
        .in_tag    (iss.dest_tag[i]),
        .a         (opa[i]),
        .b         (opb[i]),
        .hold      (hold[i]),
        .out_valid (pipe_valid),
        .out_tag   (res_tag[i]),
        .out_value (res_value[i])
      );

      assign res_valid[i] = pipe_valid && !hold[i];  // Held result must not overwrite buffer

      always_ff @(posedge clock) begin
        if (reset) begin
          in_flight <= '0;
        end else begin
          in_flight <= in_flight + CNT_W'(iss.issue[i]) - CNT_W'(res_valid[i]);
        end
      end
      assign unit_busy[i] = (in_flight != '0);
    end
  end

endmodule

/* hw/rename_dispatch.sv */
`timescale 1ns/1ps

module rename_dispatch import ooo_pkg::*; (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  op_t                 inst_op,
  input  areg_t               inst_dest,
  input  areg_t               inst_src1,
  input  areg_t               inst_src2,
  input  areg_t               rd_addr,
  input  data_t               inst_imm,
  output logic                inst_accept,
  output tag_t                rd_tag,
  input  logic [NUM_TAGS-1:0] rs_ref,
  dispatch_if.source          dsp,
  cdb_if.monitor              cdb
);

  tag_t                rat [NUM_AREGS];  // Register alias table
  logic [NUM_TAGS-1:0] tag_ready;        // Value present in value file
  logic [NUM_TAGS-1:0] tag_alloc;        // Owned by a register or in flight
  logic [NUM_TAGS-1:0] mapped;           // Named by some alias entry
  logic [NUM_TAGS-1:0] reclaim;          // Released at this edge
  logic [NUM_TAGS-1:0] cdb_hit;          // Decoded broadcast tag
  tag_t                free_tag;         // Lowest unallocated tag
  logic                have_free;
  tag_t                src1_tag;
  tag_t                src2_tag;

  always_comb begin
    mapped = '0;
    for (int r = 0; r < NUM_AREGS; r++) begin
      mapped[rat[r]] = 1'b1;  // r0 keeps tag 0 mapped forever
    end
  end

  always_comb begin
    cdb_hit = '0;
    if (cdb.cdb_valid) begin
      cdb_hit[cdb.cdb_tag] = 1'b1;
    end
  end

  // Unmapped, completed and no longer read by any station entry
  assign reclaim = tag_alloc & ~mapped & tag_ready & ~rs_ref;

  always_comb begin
    free_tag  = '0;
    have_free = 1'b0;
    for (int t = NUM_TAGS - 1; t > 0; t--) begin  // Downward scan leaves the lowest
      if (!tag_alloc[t]) begin
        free_tag  = tag_t'(t);
        have_free = 1'b1;
      end
    end
  end

  // LI has no real sources, point them at the always-ready zero tag
  assign src1_tag = (inst_op == LI) ? '0 : rat[inst_src1];
  assign src2_tag = (inst_op == LI) ? '0 : rat[inst_src2];

  assign inst_accept     = inst_valid && dsp.slot_free && have_free;
  assign dsp.dispatch_en = inst_accept;
  assign dsp.fu          = op_fu(inst_op);
  assign dsp.op          = inst_op;
  assign dsp.dest_tag    = free_tag;
  assign dsp.src1_tag    = src1_tag;
  assign dsp.src1_ready  = tag_ready[src1_tag] | cdb_hit[src1_tag];  // Completes this cycle
  assign dsp.src2_tag    = src2_tag;
  assign dsp.src2_ready  = tag_ready[src2_tag] | cdb_hit[src2_tag];
  assign dsp.imm         = inst_imm;
  assign rd_tag          = rat[rd_addr];  // External register read

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        rat[r] <= tag_t'(r);  // Identity mapping
      end
      tag_ready <= '1;
      tag_alloc <= {{(NUM_TAGS - NUM_AREGS){1'b0}}, {NUM_AREGS{1'b1}}};
    end else begin
      tag_ready <= tag_ready | cdb_hit;
      tag_alloc <= tag_alloc & ~reclaim;
      if (inst_accept) begin
        tag_ready[free_tag] <= 1'b0;  // Pending until broadcast
        tag_alloc[free_tag] <= 1'b1;
        if (inst_dest != '0) begin
          rat[inst_dest] <= free_tag;  // r0 result lands in an orphan tag
        end
      end
    end
  end

endmodule

/* reservation_station/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; #(
  parameter int NUM_RS = ooo_pkg::NUM_RS
) (
  input  logic                clock,
  input  logic                reset,
  dispatch_if.sink            dsp,
  issue_if.source             iss,
  cdb_if.monitor              cdb,
  output logic [NUM_TAGS-1:0] rs_ref,
  output logic                busy
);

  localparam int IDX_W = (NUM_RS > 1) ? $clog2(NUM_RS) : 1;

  logic [NUM_RS-1:0] ent_busy;
  op_t               ent_op   [NUM_RS];
  tag_t              ent_dest [NUM_RS];
  data_t             ent_imm  [NUM_RS];
  tag_t              ent_t1   [NUM_RS];  // Source tags
  tag_t              ent_t2   [NUM_RS];
  logic [NUM_RS-1:0] ent_r1;             // Source ready bits
  logic [NUM_RS-1:0] ent_r2;
  logic [NUM_RS-1:0] wake1;              // Bus matches a source now
  logic [NUM_RS-1:0] wake2;
  logic [NUM_RS-1:0] ready;              // Both operands available
  logic [NUM_RS-1:0] avail;              // Free for dispatch at this edge
  logic [IDX_W-1:0]  pick;               // Entry taking the dispatch

  always_comb begin
    for (int i = 0; i < NUM_RS; i++) begin
      wake1[i]     = cdb.cdb_valid && (cdb.cdb_tag == ent_t1[i]);
      wake2[i]     = cdb.cdb_valid && (cdb.cdb_tag == ent_t2[i]);  // Own compare per operand
      ready[i]     = ent_busy[i] && (ent_r1[i] || wake1[i]) && (ent_r2[i] || wake2[i]);
      iss.issue[i] = ready[i] && iss.fu_free[i];  // Structural hazard check
      avail[i]     = !ent_busy[i] || iss.issue[i];
    end
  end

  assign iss.op       = ent_op;
  assign iss.dest_tag = ent_dest;
  assign iss.src1_tag = ent_t1;
  assign iss.src2_tag = ent_t2;
  assign iss.imm      = ent_imm;

  always_comb begin
    dsp.slot_free = 1'b0;
    pick          = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin  // Lowest matching entry wins
      if (avail[i] && (RS_FU_LIST[i] == dsp.fu)) begin
        dsp.slot_free = 1'b1;
        pick          = IDX_W'(i);
      end
    end
  end

  // Tags still to be read, held back from reclamation
  always_comb begin
    rs_ref = '0;
    for (int i = 0; i < NUM_RS; i++) begin
      if (ent_busy[i]) begin
        rs_ref[ent_t1[i]] = 1'b1;
        rs_ref[ent_t2[i]] = 1'b1;
      end
    end
  end

  assign busy = |ent_busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_busy <= '0;
    end else begin
      ent_busy <= ent_busy & ~iss.issue;  // Cleared in the issue cycle
      if (dsp.dispatch_en) begin
        ent_busy[pick] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    ent_r1 <= ent_r1 | wake1;
    ent_r2 <= ent_r2 | wake2;
    if (dsp.dispatch_en) begin
      ent_op[pick]   <= dsp.op;
      ent_dest[pick] <= dsp.dest_tag;
      ent_imm[pick]  <= dsp.imm;
      ent_t1[pick]   <= dsp.src1_tag;
      ent_t2[pick]   <= dsp.src2_tag;
      ent_r1[pick]   <= dsp.src1_ready;
      ent_r2[pick]   <= dsp.src2_ready;
    end
  end

endmodule

/* hw/completion_bus.sv */
`timescale 1ns/1ps

module completion_bus import ooo_pkg::*; #(
  parameter int NUM_RS = ooo_pkg::NUM_RS
) (
  input  logic              clock,
  input  logic              reset,
  input  logic [NUM_RS-1:0] res_valid,
  input  tag_t              res_tag   [NUM_RS],
  input  data_t             res_value [NUM_RS],
  output logic [NUM_RS-1:0] buf_full,
  input  tag_t              rf_tag1   [NUM_RS],
  input  tag_t              rf_tag2   [NUM_RS],
  output data_t             rf_val1   [NUM_RS],
  output data_t             rf_val2   [NUM_RS],
  input  tag_t              rd_tag,
  output data_t             rd_data,
  cdb_if.source             cdb,
  output logic              busy
);

  logic [NUM_RS-1:0] buf_valid;        // One result buffer per unit
  tag_t              buf_tag   [NUM_RS];
  data_t             buf_value [NUM_RS];
  logic [NUM_RS-1:0] grant;
  logic              found;            // Some buffer wins the bus
  tag_t              win_tag;
  data_t             win_value;
  data_t             vfile [NUM_TAGS]; // Physical value file

  // Multiplier units first, then ALUs in entry order
  always_comb begin
    grant     = '0;
    found     = 1'b0;
    win_tag   = '0;
    win_value = '0;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < NUM_RS; i++) begin
        if (!found && buf_valid[i] && ((RS_FU_LIST[i] == FU_MUL) == (pass == 0))) begin
          grant[i]  = 1'b1;
          found     = 1'b1;
          win_tag   = buf_tag[i];
          win_value = buf_value[i];
        end
      end
    end
  end

  assign cdb.cdb_valid = found;
  assign cdb.cdb_tag   = win_tag;
  assign cdb.cdb_value = win_value;
  assign cdb.grant     = grant;
  assign buf_full      = buf_valid;
  assign busy          = |buf_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      buf_valid <= '0;
    end else begin
      buf_valid <= res_valid | (buf_valid & ~grant);  // Refill allowed while draining
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_RS; i++) begin
      if (res_valid[i]) begin
        buf_tag[i]   <= res_tag[i];
        buf_value[i] <= res_value[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        vfile[t] <= '0;  // Initial registers read zero
      end
    end else if (found && win_tag != '0) begin
      vfile[win_tag] <= win_value;  // Tag 0 stays zero
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_RS; i++) begin
      rf_val1[i] = vfile[rf_tag1[i]];
      rf_val2[i] = vfile[rf_tag2[i]];
    end
  end

  assign rd_data = vfile[rd_tag];

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
  parameter int NUM_RS     = ooo_pkg::NUM_RS,
  parameter int MUL_STAGES = ooo_pkg::MUL_STAGES
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  inst_valid,
  input  op_t   inst_op,
  input  areg_t inst_dest,
  input  areg_t inst_src1,
  input  areg_t inst_src2,
  input  data_t inst_imm,
  output logic  inst_accept,
  input  areg_t rd_addr,
  output data_t rd_data,
  output logic  cdb_valid,
  output tag_t  cdb_tag,
  output data_t cdb_value,
  output logic  core_busy
);

  dispatch_if                  dsp_bus ();
  issue_if #(.NUM_RS(NUM_RS))  iss_bus ();
  cdb_if   #(.NUM_RS(NUM_RS))  cdb_bus ();

  logic [NUM_TAGS-1:0] rs_ref;              // Tags read by waiting entries
  tag_t                rd_tag;
  logic [NUM_RS-1:0]   res_valid;
  tag_t                res_tag   [NUM_RS];
  data_t               res_value [NUM_RS];
  logic [NUM_RS-1:0]   buf_full;
  tag_t                rf_tag1   [NUM_RS];  // Operand read ports
  tag_t                rf_tag2   [NUM_RS];
  data_t               rf_val1   [NUM_RS];
  data_t               rf_val2   [NUM_RS];
  logic                rs_busy;
  logic                ex_busy;
  logic                cb_busy;

  rename_dispatch u_rename (
    .clock, .reset, .inst_valid, .inst_op, .inst_dest, .inst_src1, .inst_src2,
    .rd_addr, .inst_imm, .inst_accept, .rd_tag, .rs_ref,
    .dsp (dsp_bus),
    .cdb (cdb_bus)
  );

  reservation_station #(.NUM_RS(NUM_RS)) u_rs (
    .clock, .reset, .rs_ref,
    .dsp  (dsp_bus),
    .iss  (iss_bus),
    .cdb  (cdb_bus),
    .busy (rs_busy)
  );

  execute_units #(.NUM_RS(NUM_RS), .MUL_STAGES(MUL_STAGES)) u_exec (
    .clock, .reset, .res_valid, .res_tag, .res_value, .buf_full,
    .rf_tag1, .rf_tag2, .rf_val1, .rf_val2,
    .iss  (iss_bus),
    .cdb  (cdb_bus),
    .busy (ex_busy)
  );

  completion_bus #(.NUM_RS(NUM_RS)) u_cbus (
    .clock, .reset, .res_valid, .res_tag, .res_value, .buf_full,
    .rf_tag1, .rf_tag2, .rf_val1, .rf_val2, .rd_tag, .rd_data,
    .cdb  (cdb_bus),
    .busy (cb_busy)
  );

  assign cdb_valid = cdb_bus.cdb_valid;
  assign cdb_tag   = cdb_bus.cdb_tag;
  assign cdb_value = cdb_bus.cdb_value;
  assign core_busy = rs_busy | ex_busy | cb_busy;  // Work queued anywhere

endmodule

/* verification/ooo_core_props.sv */
`timescale 1ns/1ps

module ooo_core_props import ooo_pkg::*; (
  input logic clock,
  input logic reset,
  input logic inst_valid,
  input logic inst_accept,
  input logic cdb_valid,
  input tag_t cdb_tag
);

  logic [NUM_TAGS-1:0] seen;  // Tags broadcast since the last accept

  always_ff @(posedge clock) begin
    if (reset) begin
      seen <= '0;
    end else if (inst_accept) begin
      seen <= '0;  // New tag handed out so reuse is legal again
      if (cdb_valid) begin
        seen[cdb_tag] <= 1'b1;  // Broadcast in the accept cycle still counts
      end
    end else if (cdb_valid) begin
      seen[cdb_tag] <= 1'b1;
    end
  end

  no_zero_tag: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_tag != '0)
    else $error("Broadcast carried the zero register tag");

  accept_needs_valid: assert property (@(posedge clock) disable iff (reset)
    inst_accept |-> inst_valid)
    else $error("inst_accept high while inst_valid low");

  quiet_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !cdb_valid)
    else $error("cdb_valid high in the first cycle after reset");

  single_broadcast: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> !seen[cdb_tag])
    else $error("Tag broadcast twice with no accept in between");

endmodule

/* verification/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

  typedef struct packed {
    op_t   op;
    areg_t dest;
    areg_t src1;
    areg_t src2;
    data_t imm;
    logic  sync;   // Drain and compare registers after this row
    logic  stall;  // Section must see inst_accept drop
  } row_t;

  logic  clock;
  logic  reset;
  logic  inst_valid;
  op_t   inst_op;
  areg_t inst_dest;
  areg_t inst_src1;
  areg_t inst_src2;
  data_t inst_imm;
  logic  inst_accept;
  areg_t rd_addr;
  data_t rd_data;
  logic  cdb_valid;
  tag_t  cdb_tag;
  data_t cdb_value;
  logic  core_busy;

  row_t                rows [$];                // Stimulus table
  data_t               model_regs [NUM_AREGS];  // In-order reference state
  data_t               pending [$];             // Accepted results not yet broadcast
  logic [NUM_TAGS-1:0] tags_seen;               // Broadcast since the last accept
  int                  errors;
  int                  accepts;
  int                  broadcasts;
  int                  stall_cycles;            // Cycles with inst_valid but no accept
  int                  cycles;
  int                  cycle_limit;

  ooo_core #(.NUM_RS(NUM_RS), .MUL_STAGES(MUL_STAGES)) DUT (
    .clock, .reset, .inst_valid, .inst_op, .inst_dest, .inst_src1, .inst_src2,
    .inst_imm, .inst_accept, .rd_addr, .rd_data, .cdb_valid, .cdb_tag, .cdb_value,
    .core_busy
  );

  bind ooo_core ooo_core_props props (
    .clock, .reset, .inst_valid, .inst_accept, .cdb_valid, .cdb_tag
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;  // 4 ns period

  always @(negedge clock) begin  // Outputs settled mid-cycle
    int hit;
    if (cdb_valid) begin
      broadcasts++;
      hit = -1;
      foreach (pending[k]) begin
        if (hit < 0 && pending[k] == cdb_value) hit = k;  // Any outstanding result
      end
      if (hit < 0) begin
        errors++;
        $display("MISMATCH cdb_value: got %h, no accepted row expects it", cdb_value);
      end else begin
        pending.delete(hit);
      end
      if (cdb_tag == '0 || tags_seen[cdb_tag]) begin
        errors++;
        $display("MISMATCH cdb_tag: got %h, zero or repeated since the last accept",
                 cdb_tag);
      end
    end
    if (inst_accept) tags_seen = '0;  // Fresh tag handed out at this edge
    if (cdb_valid) tags_seen[cdb_tag] = 1'b1;
    if (inst_valid && !inst_accept) stall_cycles++;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the core stopped accepting or completing", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic void add_row(op_t op, int dest, int src1, int src2, int imm,
                                  bit sync, bit stall);
    row_t row;
    row.op    = op;
    row.dest  = areg_t'(dest);
    row.src1  = areg_t'(src1);
    row.src2  = areg_t'(src2);
    row.imm   = data_t'(imm);
    row.sync  = sync;
    row.stall = stall;
    rows.push_back(row);
  endfunction

  function automatic data_t model_exec(row_t row);
    data_t a;
    data_t b;
    data_t res;
    a = model_regs[row.src1];
    b = model_regs[row.src2];
    case (row.op)
      ADD:     res = a + b;
      SUB:     res = a - b;
      AND:     res = a & b;
      XOR:     res = a ^ b;
      LI:      res = row.imm;
      MUL:     res = a * b;  // Low half of the product
      default: res = '0;
    endcase
    if (row.dest != '0) model_regs[row.dest] = res;  // r0 discards
    return res;
  endfunction

  function automatic void build_table();
    logic [2:0] opv;
    // Dependent chain where ADD sees r1 broadcast while dispatching
    add_row(LI,  1, 0, 0, 'h0005, 0, 0);
    add_row(LI,  2, 0, 0, 'h0003, 0, 0);
    add_row(ADD, 3, 1, 2, 0, 0, 0);
    add_row(SUB, 4, 3, 1, 0, 0, 0);
    add_row(AND, 5, 4, 3, 0, 0, 0);
    add_row(XOR, 6, 5, 2, 0, 0, 0);
    add_row(MUL, 7, 6, 3, 0, 0, 0);
    add_row(ADD, 1, 7, 1, 0, 1, 0);
    // MUL burst whose dependents back up the station
    add_row(MUL, 1, 1, 2, 0, 0, 0);
    add_row(MUL, 2, 2, 3, 0, 0, 0);
    add_row(MUL, 3, 1, 1, 0, 0, 0);
    add_row(MUL, 4, 2, 3, 0, 0, 0);
    add_row(ADD, 5, 4, 1, 0, 0, 0);
    add_row(SUB, 6, 5, 3, 0, 0, 0);
    add_row(XOR, 7, 6, 4, 0, 0, 0);
    add_row(MUL, 1, 7, 5, 0, 0, 0);
    add_row(ADD, 2, 1, 6, 0, 1, 1);
    // r0 writes and a rewrite behind a waiting reader
    add_row(LI,  0, 0, 0, 'h0055, 0, 0);
    add_row(ADD, 0, 1, 2, 0, 0, 0);
    add_row(ADD, 1, 0, 2, 0, 0, 0);
    add_row(MUL, 3, 1, 2, 0, 0, 0);
    add_row(ADD, 4, 3, 2, 0, 0, 0);
    add_row(LI,  3, 0, 0, 'h1234, 0, 0);  // New r3 while ADD still waits on old one
    add_row(SUB, 5, 3, 4, 0, 0, 0);
    add_row(XOR, 6, 0, 5, 0, 1, 0);
    for (int i = 0; i < 40; i++) begin
      opv = 3'($urandom_range(5, 0));
      add_row(op_t'(opv), $urandom_range(7, 0), $urandom_range(7, 0),
              $urandom_range(7, 0), $urandom_range(16'hffff, 0), i == 39, 0);
    end
  endfunction

  // Entered 1 ns past an edge and left 1 ns past the accept edge
  task automatic apply_row(row_t row);
    logic done;
    done       = 1'b0;
    inst_valid = 1'b1;
    inst_op    = row.op;
    inst_dest  = row.dest;
    inst_src1  = row.src1;
    inst_src2  = row.src2;
    inst_imm   = row.imm;
    while (!done) begin
      @(negedge clock);
      done = inst_accept;  // Taken at the coming edge
      @(posedge clock);
      #1;
    end
    accepts++;
    pending.push_back(model_exec(row));
    inst_valid = 1'b0;
  endtask

  task automatic drain_core();
    @(negedge clock);
    while (core_busy) begin
      @(negedge clock);
    end
  endtask

  task automatic compare_regs();
    for (int r = 0; r < NUM_AREGS; r++) begin
      @(posedge clock);
      #1;
      rd_addr = areg_t'(r);
      @(negedge clock);
      if (rd_data !== model_regs[r]) begin
        errors++;
        $display("MISMATCH rd_data r%0d: got %h expected %h", r, rd_data, model_regs[r]);
      end
    end
    if (broadcasts != accepts) begin  // One completion per accepted row
      errors++;
      $display("MISMATCH broadcasts: got %h expected %h", broadcasts, accepts);
    end
    @(posedge clock);
    #1;
  endtask

  initial begin
    int section_stalls;
    void'($urandom(67579));
    errors       = 0;
    accepts      = 0;
    broadcasts   = 0;
    stall_cycles = 0;
    cycles       = 0;
    tags_seen    = '0;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst_op      = ADD;
    inst_dest    = '0;
    inst_src1    = '0;
    inst_src2    = '0;
    inst_imm     = '0;
    rd_addr      = '0;
    for (int r = 0; r < NUM_AREGS; r++) model_regs[r] = '0;
    build_table();
    cycle_limit = rows.size() * 20 + 100;

    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    if (cdb_valid !== 1'b0 || inst_accept !== 1'b0 || core_busy !== 1'b0) begin
      errors++;
      $display("MISMATCH outputs after reset: cdb_valid %h inst_accept %h core_busy %h",
               cdb_valid, inst_accept, core_busy);
    end
    compare_regs();  // All registers start at zero

    section_stalls = stall_cycles;
    foreach (rows[i]) begin
      apply_row(rows[i]);
      if (rows[i].sync) begin
        drain_core();
        compare_regs();
        if (rows[i].stall && stall_cycles == section_stalls) begin
          errors++;
          $display("inst_accept never dropped although the station should have filled");
        end
        section_stalls = stall_cycles;
      end
    end

    $display("Done: errors %0d, accepts %0d, broadcasts %0d, stall cycles %0d",
             errors, accepts, broadcasts, stall_cycles);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
common/ooo_pkg.sv
common/ooo_ifs.sv
execute/mul_pipe.sv
execute/execute_units.sv
hw/rename_dispatch.sv
reservation_station/reservation_station.sv
hw/completion_bus.sv
hw/ooo_core.sv
verification/ooo_core_props.sv
verification/ooo_core_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f build.f -o ooo_core_sim
	./obj_dir/ooo_core_sim | tee /dev/stderr | grep "TESTS PASSED"

clean:
	rm -rf obj_dir
